//--- include/wdata_defs.svh
`ifndef WDATA_DEFS_SVH
`define WDATA_DEFS_SVH

// ==============================
// Slot storage
// ==============================

`define WBUF_DEPTH          128     // Write data slots.
`define WBUF_SLOT_W         7

// Beat payload.
`define WBUF_DATA_W         256
`define WBUF_STRB_W         32      // One strobe per byte.
`define WBUF_ADDR_W         32      // DRAM address.

// ==============================
// Egress side
// ==============================

`define WBUF_DESC_DEPTH     128     // Descriptor FIFO entries.
`define WBUF_DRAM_CREDITS   4       // Held after reset.

`endif

//--- rtl/wdata_pkg.sv
`include "wdata_defs.svh"

package wdata_pkg;

    // ==============================
    // Slot and payload vectors
    // ==============================

    // Index into the data SRAM.
    typedef logic [`WBUF_SLOT_W-1:0] slot_t;

    // Full write beat and its byte enables.
    typedef logic [`WBUF_DATA_W-1:0] data_t;
    typedef logic [`WBUF_STRB_W-1:0] strb_t;

    // One SRAM macro is half a beat wide.
    typedef logic [`WBUF_DATA_W/2-1:0] half_t;

    // DRAM side byte address.
    typedef logic [`WBUF_ADDR_W-1:0] addr_t;

endpackage

//--- rtl/wbuf_if_pkg.sv
package wbuf_if_pkg;

    // ==============================
    // External ports
    // ==============================

    // Host write beat, costs one host credit.
    typedef struct packed {
        logic             valid;
        wdata_pkg::addr_t addr;
        wdata_pkg::data_t data;
        wdata_pkg::strb_t strb;
    } host_wr_t;

    // Beat toward DRAM, costs one DRAM credit.
    typedef struct packed {
        logic             valid;
        wdata_pkg::addr_t addr;
        wdata_pkg::data_t data;
        wdata_pkg::strb_t strb;
    } dram_wr_t;

    // Queued per beat, data stays in the SRAM.
    typedef struct packed {
        wdata_pkg::slot_t slot;
        wdata_pkg::addr_t addr;
        wdata_pkg::strb_t strb;
    } wdesc_t;

endpackage

//--- rtl/sram_2p_bw.sv
`include "wdata_defs.svh"

module sram_2p_bw (
    input  logic             clk,
    input  logic             ren,
    input  logic             wen,
    input  wdata_pkg::slot_t ra,
    input  wdata_pkg::slot_t wa,
    input  wdata_pkg::half_t di,
    input  wdata_pkg::half_t bwen,   // Active low, per bit.
    output wdata_pkg::half_t dout
);

    wdata_pkg::half_t mem [`WBUF_DEPTH];

    // Write port.
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[wa] <= (mem[wa] & bwen) | (di & ~bwen);
        end
    end

    // Read port, output holds while idle.
    always_ff @(posedge clk) begin
        if (ren) begin
            dout <= mem[ra];
        end
    end

endmodule

//--- rtl/wdata_sram.sv
module wdata_sram (
    input  logic             clk,
    input  wdata_pkg::data_t din,
    input  wdata_pkg::strb_t mask,
    input  logic             wr,
    input  wdata_pkg::slot_t waddr,
    input  logic             re,
    input  wdata_pkg::slot_t raddr,
    output wdata_pkg::data_t dout
);

    wdata_pkg::data_t bit_en;
    wdata_pkg::half_t bwen_lo;
    wdata_pkg::half_t bwen_hi;

    // Byte strobes to bit enables.
    always_comb begin
        for (int i = 0; i < $bits(wdata_pkg::strb_t); i++) begin
            bit_en[i*8 +: 8] = {8{mask[i]}};
        end
    end

    // Macro enables are active low.
    assign bwen_lo = ~bit_en[$bits(wdata_pkg::half_t)-1:0];
    assign bwen_hi = ~bit_en[$bits(wdata_pkg::data_t)-1:$bits(wdata_pkg::half_t)];

    sram_2p_bw u_sram_lo (
        .clk  (clk),
        .ren  (re),
        .wen  (wr),
        .ra   (raddr),
        .wa   (waddr),
        .di   (din[$bits(wdata_pkg::half_t)-1:0]),
        .bwen (bwen_lo),
        .dout (dout[$bits(wdata_pkg::half_t)-1:0])
    );

    sram_2p_bw u_sram_hi (
        .clk  (clk),
        .ren  (re),
        .wen  (wr),
        .ra   (raddr),
        .wa   (waddr),
        .di   (din[$bits(wdata_pkg::data_t)-1:$bits(wdata_pkg::half_t)]),
        .bwen (bwen_hi),
        .dout (dout[$bits(wdata_pkg::data_t)-1:$bits(wdata_pkg::half_t)])
    );

endmodule

//--- rtl/slot_free_list.sv
`include "wdata_defs.svh"

module slot_free_list (
    input  logic             clk,
    input  logic             reset,
    input  logic             alloc,
    input  logic             release_en,
    input  wdata_pkg::slot_t release_slot,
    output wdata_pkg::slot_t alloc_slot
);

    logic [`WBUF_SLOT_W:0]   fresh_cnt;      // Slots handed out so far.
    logic                    fresh_done;
    wdata_pkg::slot_t        rcy_mem [`WBUF_DEPTH];
    wdata_pkg::slot_t        rcy_wr_ptr;
    wdata_pkg::slot_t        rcy_rd_ptr;
    logic [`WBUF_SLOT_W:0]   rcy_cnt;
    logic                    rcy_empty;
    logic                    bypass;
    logic                    rcy_push;
    logic                    rcy_pop;

    assign fresh_done = (fresh_cnt == (`WBUF_SLOT_W+1)'(`WBUF_DEPTH));
    assign rcy_empty  = (rcy_cnt == '0);

    // Released slot goes straight back out when nothing is queued.
    assign bypass   = alloc && fresh_done && rcy_empty && release_en;
    assign rcy_push = release_en && !bypass;
    assign rcy_pop  = alloc && fresh_done && !rcy_empty;

    always_comb begin
        if (!fresh_done) begin
            alloc_slot = fresh_cnt[`WBUF_SLOT_W-1:0];
        end else if (rcy_empty) begin
            alloc_slot = release_slot;
        end else begin
            alloc_slot = rcy_mem[rcy_rd_ptr];
        end
    end

    // ==============================
    // Control state
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            fresh_cnt  <= '0;
            rcy_wr_ptr <= '0;
            rcy_rd_ptr <= '0;
            rcy_cnt    <= '0;
        end else begin
            if (alloc && !fresh_done) fresh_cnt <= fresh_cnt + 1'b1;
            if (rcy_push) rcy_wr_ptr <= rcy_wr_ptr + 1'b1;
            if (rcy_pop) rcy_rd_ptr <= rcy_rd_ptr + 1'b1;
            rcy_cnt <= rcy_cnt + (`WBUF_SLOT_W+1)'(rcy_push) - (`WBUF_SLOT_W+1)'(rcy_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (rcy_push) begin
            rcy_mem[rcy_wr_ptr] <= release_slot;
        end
    end

endmodule

//--- rtl/wdata_ingress.sv
module wdata_ingress (
    input  logic                  clk,
    input  logic                  reset,
    input  wbuf_if_pkg::host_wr_t host_wr,
    input  wdata_pkg::slot_t      alloc_slot,
    output logic                  alloc,
    output logic                  wr,
    output wdata_pkg::slot_t      waddr,
    output wdata_pkg::data_t      din,
    output wdata_pkg::strb_t      mask,
    output wbuf_if_pkg::wdesc_t   desc,
    output logic                  desc_push
);

    logic [31:0] beat_cnt;   // Accepted beats since reset.

    // ==============================
    // Slot allocation and SRAM write
    // ==============================

    // Host holds a credit, so a slot is always free.
    assign alloc = host_wr.valid;

    assign wr    = host_wr.valid;
    assign waddr = alloc_slot;
    assign din   = host_wr.data;
    assign mask  = host_wr.strb;   // Strobes become byte write enables.

    // Descriptor enters egress on the same edge as the write.
    assign desc_push = host_wr.valid;
    assign desc      = '{
        slot: alloc_slot,
        addr: host_wr.addr,
        strb: host_wr.strb
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_cnt <= '0;
        end else if (host_wr.valid) begin
            beat_cnt <= beat_cnt + 32'd1;
        end
    end

endmodule

//--- rtl/wdata_egress.sv
`include "wdata_defs.svh"

module wdata_egress (
    input  logic                  clk,
    input  logic                  reset,
    input  wbuf_if_pkg::wdesc_t   desc,
    input  logic                  desc_push,
    input  wdata_pkg::data_t      dout,
    input  logic                  dram_credit,
    output logic                  re,
    output wdata_pkg::slot_t      raddr,
    output wbuf_if_pkg::dram_wr_t dram_wr,
    output logic                  release_en,
    output wdata_pkg::slot_t      release_slot
);

    localparam int PTR_W = $clog2(`WBUF_DESC_DEPTH);
    localparam int CRD_W = $clog2(`WBUF_DRAM_CREDITS + 1);

    wbuf_if_pkg::wdesc_t desc_mem [`WBUF_DESC_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      desc_cnt;
    logic [CRD_W-1:0]    credits;
    logic                pop;
    wbuf_if_pkg::wdesc_t s1_desc;    // Travels with the SRAM read.
    logic                s2_valid;
    wbuf_if_pkg::wdesc_t s2_desc;
    logic                out_valid;
    wbuf_if_pkg::wdesc_t out_desc;
    wdata_pkg::data_t    out_data;

    assign pop = (desc_cnt != '0) && (credits != '0);

    // ==============================
    // Descriptor FIFO and credits
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            desc_cnt <= '0;
            credits  <= CRD_W'(`WBUF_DRAM_CREDITS);
        end else begin
            if (desc_push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            desc_cnt <= desc_cnt + (PTR_W+1)'(desc_push) - (PTR_W+1)'(pop);
            case ({pop, dram_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // Pop and return cancel.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (desc_push) begin
            desc_mem[wr_ptr] <= desc;
        end
    end

    // ==============================
    // Read pipeline
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            re        <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            re        <= pop;
            s2_valid  <= re;      // Read data lands this cycle.
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_desc  <= desc_mem[rd_ptr];
        s2_desc  <= s1_desc;
        out_desc <= s2_desc;
        out_data <= dout;
    end

    assign raddr = s1_desc.slot;

    // Slot frees in the cycle its beat goes out.
    assign release_en   = out_valid;
    assign release_slot = out_desc.slot;

    assign dram_wr = '{
        valid: out_valid,
        addr:  out_desc.addr,
        data:  out_data,
        strb:  out_desc.strb
    };

endmodule

//--- rtl/wdata_buffer_top.sv
module wdata_buffer_top (
    input  logic                  clk,
    input  logic                  reset,
    input  wbuf_if_pkg::host_wr_t host_wr,
    input  logic                  dram_credit,
    output wbuf_if_pkg::dram_wr_t dram_wr,
    output logic                  host_credit
);

    logic                alloc;
    wdata_pkg::slot_t    alloc_slot;
    logic                wr;
    wdata_pkg::slot_t    waddr;
    wdata_pkg::data_t    din;
    wdata_pkg::strb_t    mask;
    wbuf_if_pkg::wdesc_t desc;
    logic                desc_push;
    logic                re;
    wdata_pkg::slot_t    raddr;
    wdata_pkg::data_t    dout;
    logic                release_pulse;
    wdata_pkg::slot_t    release_slot;

    // ==============================
    // Host side
    // ==============================
    wdata_ingress u_ingress (
        .clk        (clk),
        .reset      (reset),
        .host_wr    (host_wr),
        .alloc_slot (alloc_slot),
        .alloc      (alloc),
        .wr         (wr),
        .waddr      (waddr),
        .din        (din),
        .mask       (mask),
        .desc       (desc),
        .desc_push  (desc_push)
    );

    slot_free_list u_free_list (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .release_en   (release_pulse),
        .release_slot (release_slot),
        .alloc_slot   (alloc_slot)
    );

    wdata_sram u_sram (
        .clk   (clk),
        .din   (din),
        .mask  (mask),
        .wr    (wr),
        .waddr (waddr),
        .re    (re),
        .raddr (raddr),
        .dout  (dout)
    );

    // ==============================
    // DRAM side
    // ==============================
    wdata_egress u_egress (
        .clk          (clk),
        .reset        (reset),
        .desc         (desc),
        .desc_push    (desc_push),
        .dout         (dout),
        .dram_credit  (dram_credit),
        .re           (re),
        .raddr        (raddr),
        .dram_wr      (dram_wr),
        .release_en   (release_pulse),
        .release_slot (release_slot)
    );

    assign host_credit = release_pulse;   // One credit per freed slot.

endmodule

//--- test/wdata_buffer_assert.sv
`include "wdata_defs.svh"

module wdata_buffer_assert (
    input logic        clk,
    input logic        reset,
    input logic        host_valid,
    input logic        host_credit,
    input logic        re,
    input logic        dram_valid,
    input logic [31:0] beat_cnt
);
    timeunit 1ns;
    timeprecision 1ns;

    logic [31:0] credits_back;
    logic [31:0] pops;
    logic [31:0] outs;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits_back <= '0;
            pops         <= '0;
            outs         <= '0;
        end else begin
            if (host_credit) credits_back <= credits_back + 32'd1;
            if (re) pops <= pops + 32'd1;            // One read per pop.
            if (dram_valid) outs <= outs + 32'd1;
        end
    end

    // ==============================
    // Protocol properties
    // ==============================
    host_holds_credit: assert property (@(posedge clk) disable iff (reset)
        host_valid |-> (beat_cnt - credits_back) < 32'(`WBUF_DEPTH))
        else $error("host beat accepted with no host credit left");

    read_idle_in_reset: assert property (@(posedge clk) reset |=> !re)
        else $error("SRAM read enable high during reset");

    output_follows_pop: assert property (@(posedge clk) disable iff (reset)
        dram_valid |-> outs < pops)
        else $error("DRAM write beat without an earlier descriptor pop");

endmodule

//--- test/wdata_buffer_tb.sv
`include "wdata_defs.svh"

module wdata_buffer_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int SETTLE = 10;

    typedef enum logic [1:0] {STRB_ONES, STRB_ZERO, STRB_ALT, STRB_RAND} strb_sel_e;
    typedef enum logic [1:0] {CRD_NORMAL, CRD_HOLD, CRD_DELAY} crd_mode_e;

    typedef struct {
        string            name;
        int               beats;
        wdata_pkg::addr_t base;
        strb_sel_e        strb_sel;
        crd_mode_e        crd_mode;
        logic             spaced;      // One beat in flight at a time.
    } row_t;

    typedef struct packed {
        wdata_pkg::addr_t addr;
        wdata_pkg::data_t data;
        wdata_pkg::strb_t strb;
        int               sample;      // Edge where the DUT took the beat.
        logic             timed;
    } exp_beat_t;

    logic                  clk = 1'b0;
    logic                  reset;
    wbuf_if_pkg::host_wr_t host_wr;
    logic                  dram_credit;
    wbuf_if_pkg::dram_wr_t dram_wr;
    logic                  host_credit;

    row_t        rows[$];
    exp_beat_t   exp_q[$];
    logic [31:0] lfsr = 32'h4fb2_8f69;
    int          total_beats = 0;
    int          timeout_limit = 1000;
    int          wd_cycles = 0;
    int          step_cnt = 0;
    int          host_credits = `WBUF_DEPTH;
    int          credit_backlog = 0;   // DRAM credits waiting to go back.
    int          owed = 0;             // DRAM credits held back.
    logic        withhold = 1'b0;
    logic        row_spaced = 1'b0;
    int          row_outs = 0;
    int          row_pulses = 0;
    int          row_errs = 0;
    int          err_cnt = 0;
    int          check_cnt = 0;

    wdata_buffer_top uut (
        .clk         (clk),
        .reset       (reset),
        .host_wr     (host_wr),
        .dram_credit (dram_credit),
        .dram_wr     (dram_wr),
        .host_credit (host_credit)
    );

    bind wdata_buffer_top wdata_buffer_assert u_assert (
        .clk         (clk),
        .reset       (reset),
        .host_valid  (host_wr.valid),
        .host_credit (host_credit),
        .re          (re),
        .dram_valid  (dram_wr.valid),
        .beat_cnt    (u_ingress.beat_cnt)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        wd_cycles++;
        if (wd_cycles > timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ==============================
    // Stimulus table
    // ==============================
    function automatic void add_row(input string name, input int beats,
                                    input wdata_pkg::addr_t base, input strb_sel_e sel,
                                    input crd_mode_e mode, input logic spaced);
        row_t r;
        r.name     = name;
        r.beats    = beats;
        r.base     = base;
        r.strb_sel = sel;
        r.crd_mode = mode;
        r.spaced   = spaced;
        rows.push_back(r);
        total_beats += beats;
    endfunction

    function automatic void load_table();
        add_row("single",          8, 32'h1000_0000, STRB_ONES, CRD_NORMAL, 1'b1);
        add_row("stream",         24, 32'h1001_0000, STRB_RAND, CRD_NORMAL, 1'b0);
        add_row("dram_hold",      10, 32'h2000_0000, STRB_ALT,  CRD_DELAY,  1'b0);
        add_row("spend_credits",   4, 32'h3000_0000, STRB_ONES, CRD_HOLD,   1'b0);
        add_row("fill", `WBUF_DEPTH, 32'h4000_0000, STRB_RAND, CRD_DELAY,  1'b0);
        add_row("reuse",          40, 32'h5000_0000, STRB_ALT,  CRD_NORMAL, 1'b0);
        add_row("zero_strb",       6, 32'h6000_0000, STRB_ZERO, CRD_NORMAL, 1'b1);
        add_row("rand_strb",      16, 32'h7000_0000, STRB_RAND, CRD_NORMAL, 1'b1);
        timeout_limit = 4 * total_beats + 1000;
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic wbuf_if_pkg::host_wr_t make_beat(input row_t r, input int n);
        wbuf_if_pkg::host_wr_t b;
        b.valid = 1'b1;
        b.addr  = r.base + wdata_pkg::addr_t'(n * 32);
        for (int i = 0; i < `WBUF_DATA_W; i++) b.data[i] = lfsr_bit();
        case (r.strb_sel)
            STRB_ONES: b.strb = '1;
            STRB_ZERO: b.strb = '0;
            STRB_ALT:  b.strb = {(`WBUF_STRB_W/2){2'b01}};
            default:   for (int i = 0; i < `WBUF_STRB_W; i++) b.strb[i] = lfsr_bit();
        endcase
        return b;
    endfunction

    function automatic wdata_pkg::data_t byte_mask(input wdata_pkg::strb_t strb);
        wdata_pkg::data_t m;
        m = '0;
        for (int b = 0; b < `WBUF_STRB_W; b++) begin
            if (strb[b]) m[b*8 +: 8] = 8'hff;
        end
        return m;
    endfunction

    // ==============================
    // Checking
    // ==============================
    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            err_cnt++;
            row_errs++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        err_cnt++;
        row_errs++;
    endtask

    task automatic check_output();
        exp_beat_t        e;
        wdata_pkg::data_t m;
        if (exp_q.size() == 0) begin
            report_failure("a DRAM write beat came out with nothing queued");
        end else begin
            e = exp_q.pop_front();
            m = byte_mask(e.strb);                // Disabled bytes hold stale data.
            check_value("dram_wr.addr", 256'(dram_wr.addr), 256'(e.addr));
            check_value("dram_wr.strb", 256'(dram_wr.strb), 256'(e.strb));
            check_value("dram_wr.data", dram_wr.data & m, e.data & m);
            if (e.timed) check_value("beat latency", 256'(step_cnt - e.sample), 256'(3));
        end
    endtask

    // Drive on the rising edge, sample on the falling edge.
    task automatic cycle_step(input logic send, input wbuf_if_pkg::host_wr_t beat);
        exp_beat_t e;
        @(posedge clk);
        step_cnt++;
        if (send) begin
            host_wr <= beat;
            host_credits--;
            e.addr   = beat.addr;
            e.data   = beat.data;
            e.strb   = beat.strb;
            e.sample = step_cnt + 1;
            e.timed  = row_spaced;
            exp_q.push_back(e);
        end else begin
            host_wr <= '0;
        end
        dram_credit <= (credit_backlog > 0);
        if (credit_backlog > 0) credit_backlog--;
        @(negedge clk);
        if (host_credit) begin
            host_credits++;
            row_pulses++;
        end
        if (dram_wr.valid) begin
            row_outs++;
            check_output();
            if (withhold) owed++;
            else credit_backlog++;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) cycle_step(1'b0, '0);
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   sent;
        int   quiet_from;
        int   held_pulses;
        r          = rows[idx];
        sent       = 0;
        row_outs   = 0;
        row_pulses = 0;
        row_errs   = 0;
        row_spaced = r.spaced;
        withhold   = (r.crd_mode != CRD_NORMAL);
        if (!withhold) begin
            credit_backlog += owed;
            owed = 0;
        end
        while (sent < r.beats) begin
            if (host_credits > 0) begin
                cycle_step(1'b1, make_beat(r, sent));
                sent++;
                if (r.spaced) wait_drain();
            end else begin
                cycle_step(1'b0, '0);
            end
        end
        if (r.crd_mode == CRD_NORMAL) begin
            wait_drain();
        end else begin
            repeat (SETTLE) cycle_step(1'b0, '0);
            quiet_from = row_outs;
            repeat (SETTLE) cycle_step(1'b0, '0);
            check_value("dram_wr beats after credits ran out", 256'(row_outs - quiet_from), 256'(0));
            if (row_outs > `WBUF_DRAM_CREDITS) begin
                report_failure("more DRAM beats came out than DRAM credits while held");
            end
            if (r.beats == `WBUF_DEPTH) begin
                check_value("host_credits", 256'(host_credits), 256'(0));
                check_value("host_credit pulses while held", 256'(row_pulses), 256'(0));
            end
            if (r.crd_mode == CRD_DELAY) begin
                held_pulses    = row_pulses;
                withhold       = 1'b0;
                credit_backlog += owed;
                owed           = 0;
                wait_drain();
                if (r.beats == `WBUF_DEPTH) begin
                    check_value("host_credit pulses after release",
                                256'(row_pulses - held_pulses), 256'(`WBUF_DEPTH));
                end
            end
        end
        check_value("host_credits", 256'(host_credits), 256'(`WBUF_DEPTH - exp_q.size()));
        check_value("host_credit pulses", 256'(row_pulses), 256'(row_outs));
        $display("test %s: %0d beats in, %0d beats out, %0d errors",
                 r.name, r.beats, row_outs, row_errs);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        host_wr     = '0;
        dram_credit = 1'b0;
        reset       = 1'b1;
        load_table();
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            if (c == 2) reset <= 1'b0;            // Third reset edge.
            @(negedge clk);
            check_value("dram_wr.valid", 256'(dram_wr.valid), 256'(0));
            check_value("host_credit", 256'(host_credit), 256'(0));
        end
        $display("test reset: %0d errors", row_errs);
        for (int i = 0; i < rows.size(); i++) run_row(i);
        $display("summary: %0d tests, %0d checks, %0d errors",
                 rows.size() + 1, check_cnt, err_cnt);
        if (err_cnt == 0) $display("*** TEST PASSED ***");
        else $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
rtl/wdata_pkg.sv
rtl/wbuf_if_pkg.sv
rtl/sram_2p_bw.sv
rtl/wdata_sram.sv
rtl/slot_free_list.sv
rtl/wdata_ingress.sv
rtl/wdata_egress.sv
rtl/wdata_buffer_top.sv
test/wdata_buffer_assert.sv
test/wdata_buffer_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module wdata_buffer_tb \
    -o wdata_buffer_sim \
    && ./obj_dir/wdata_buffer_sim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
